// File: Bender.yml
package:
  name: os_generator

sources:
  - design/os_gen_pkg.sv
  - design/os_block_if.sv
  - design/os_builder.sv
  - design/os_queue.sv
  - design/os_lane_driver.sv
  - design/os_generator.sv
  - target: test
    files:
      - test/os_clock_gen.sv
      - test/os_generator_tb.sv

// File: all.f
design/os_gen_pkg.sv
design/os_block_if.sv
design/os_builder.sv
design/os_queue.sv
design/os_lane_driver.sv
design/os_generator.sv
test/os_clock_gen.sv
test/os_generator_tb.sv

// File: design/os_block_if.sv
`default_nettype none

// one assembled ordered set handed from stage to stage
interface os_block_if import os_gen_pkg::*; ();

   logic       valid;
   logic       ready;
   os_block_u  block;
   os_kind_e   kind;
   lane_mode_e lane_mode;

   modport src (
      output valid,
      output block,
      output kind,
      output lane_mode,
      input  ready
   );

   modport dst (
      input  valid,
      input  block,
      input  kind,
      input  lane_mode,
      output ready
   );

endinterface

`default_nettype wire

// File: design/os_builder.sv
`default_nettype none

module os_builder import os_gen_pkg::*; (
   input  wire            pclk,
   input  wire            reset_n,
   input  wire            start,
   input  wire  [1:0]     os_type,
   input  wire  [1:0]     lane_number,
   input  symbol_t        link_number,
   input  wire  [2:0]     rate,
   input  wire            loopback,
   output logic           ready,
   os_block_if.src        out
);

   logic       valid_q;
   logic       accept;
   os_block_u  new_blk;
   os_block_u  blk_q;
   os_kind_e   kind_q;
   lane_mode_e mode_q;

   assign ready  = !valid_q || out.ready;                // empty or draining this cycle
   assign accept = start && ready;

   always_comb begin
      new_blk = '0;
      case (os_kind_e'(os_type))
         OS_TS1, OS_TS2: begin
            new_blk.f.comma   = COM_SYM;
            new_blk.f.link    = (link_number == '0) ? PAD_SYM : link_number;
            new_blk.f.lane    = PAD_SYM;                 // filled per lane on the way out
            new_blk.f.n_fts   = '0;
            case (rate)
               3'd1:    new_blk.f.rate = 8'h02;
               3'd2:    new_blk.f.rate = 8'h04;
               3'd3:    new_blk.f.rate = 8'h08;
               3'd4:    new_blk.f.rate = 8'h10;
               default: new_blk.f.rate = 8'h20;
            endcase
            new_blk.f.control = loopback ? LOOPBACK_BIT : '0;
            new_blk.f.ident   = (os_kind_e'(os_type) == OS_TS1) ? {10{TS1_ID}} : {10{TS2_ID}};
         end
         OS_SKP:  new_blk.sym[3:0] = {SKP_SYM, SKP_SYM, SKP_SYM, COM_SYM};
         default: new_blk.sym[3:0] = {EIDL_SYM, EIDL_SYM, EIDL_SYM, COM_SYM};
      endcase
   end

   always_ff @(posedge pclk or negedge reset_n) begin
      if (!reset_n) begin
         valid_q <= 1'b0;
      end else if (accept) begin
         valid_q <= 1'b1;
      end else if (out.ready) begin
         valid_q <= 1'b0;                                // handed to the queue
      end
   end

   always_ff @(posedge pclk) begin
      if (accept) begin
         blk_q  <= new_blk;
         kind_q <= os_kind_e'(os_type);
         mode_q <= lane_mode_e'(lane_number);
      end
   end

   assign out.valid     = valid_q;
   assign out.block     = blk_q;
   assign out.kind      = kind_q;
   assign out.lane_mode = mode_q;

   // a stalled block must not change under the queue
   a_hold_stable: assert property (@(posedge pclk) disable iff (!reset_n)
      out.valid && !out.ready |=> out.valid && $stable(out.block) && $stable(out.kind)
         && $stable(out.lane_mode));

endmodule

`default_nettype wire

// File: design/os_gen_pkg.sv
`default_nettype none

package os_gen_pkg;

   localparam int NUM_LANES   = 4;
   localparam int SYM_W       = 8;
   localparam int TS_LEN      = 16;
   localparam int SHORT_LEN   = 4;
   localparam int QUEUE_DEPTH = 2;

   localparam int SYM_IDX_W    = $clog2(TS_LEN);        // symbol counter width
   localparam int QPTR_W       = $clog2(QUEUE_DEPTH);
   localparam int QCNT_W       = $clog2(QUEUE_DEPTH + 1);
   localparam int LANE_SYM_IDX = 2;                     // lane number position in TS1/TS2

   typedef logic [SYM_W-1:0] symbol_t;

   localparam symbol_t COM_SYM      = 8'hBC;            // K28.5
   localparam symbol_t PAD_SYM      = 8'hF7;            // K23.7
   localparam symbol_t SKP_SYM      = 8'h1C;            // K28.0
   localparam symbol_t EIDL_SYM     = 8'h7C;            // K28.3
   localparam symbol_t TS1_ID       = 8'h4A;            // D10.2
   localparam symbol_t TS2_ID       = 8'h45;            // D5.2
   localparam symbol_t LOOPBACK_BIT = 8'h04;            // training control, loopback

   // same encoding as the os_type request port
   typedef enum logic [1:0] {
      OS_TS1  = 2'd0,
      OS_TS2  = 2'd1,
      OS_SKP  = 2'd2,
      OS_EIOS = 2'd3
   } os_kind_e;

   typedef enum logic [1:0] {
      LANE_PAD = 2'd0,
      LANE_SEQ = 2'd1,
      LANE_REV = 2'd2                                   // 3 is treated as reversed too
   } lane_mode_e;

   // symbol 0 sits in the low byte
   typedef struct packed {
      symbol_t [9:0] ident;                             // symbols 6..15
      symbol_t       control;                           // symbol 5
      symbol_t       rate;                              // symbol 4
      symbol_t       n_fts;                             // symbol 3
      symbol_t       lane;                              // symbol 2, replaced per lane
      symbol_t       link;                              // symbol 1
      symbol_t       comma;                             // symbol 0
   } os_fields_t;

   typedef union packed {
      os_fields_t             f;                        // written by the builder
      symbol_t [TS_LEN-1:0]   sym;                      // read by the lane driver
   } os_block_u;

endpackage

`default_nettype wire

// File: design/os_generator.sv
`default_nettype none

module os_generator import os_gen_pkg::*; (
   input  wire                       pclk,
   input  wire                       reset_n,
   input  wire                       start,
   input  wire     [1:0]             os_type,
   input  wire     [1:0]             lane_number,
   input  symbol_t                   link_number,
   input  wire     [2:0]             rate,
   input  wire                       loopback,
   output logic                      ready,
   output logic                      busy,
   output logic                      finish,
   output symbol_t [NUM_LANES-1:0]   os_out,
   output logic    [NUM_LANES-1:0]   data_k,
   output logic    [NUM_LANES-1:0]   data_valid
);

   os_block_if build_if ();                              // builder to queue
   os_block_if send_if ();                               // queue to lane driver

   os_builder u_builder (
      .pclk        (pclk),
      .reset_n     (reset_n),
      .start       (start),
      .os_type     (os_type),
      .lane_number (lane_number),
      .link_number (link_number),
      .rate        (rate),
      .loopback    (loopback),
      .ready       (ready),
      .out         (build_if.src)
   );

   os_queue u_queue (
      .pclk    (pclk),
      .reset_n (reset_n),
      .in      (build_if.dst),
      .out     (send_if.src)
   );

   os_lane_driver u_lane_driver (
      .pclk       (pclk),
      .reset_n    (reset_n),
      .in         (send_if.dst),
      .os_out     (os_out),
      .data_k     (data_k),
      .data_valid (data_valid),
      .busy       (busy),
      .finish     (finish)
   );

endmodule

`default_nettype wire

// File: design/os_lane_driver.sv
`default_nettype none

module os_lane_driver import os_gen_pkg::*; (
   input  wire                       pclk,
   input  wire                       reset_n,
   os_block_if.dst                   in,
   output symbol_t [NUM_LANES-1:0]   os_out,
   output logic    [NUM_LANES-1:0]   data_k,
   output logic    [NUM_LANES-1:0]   data_valid,
   output logic                      busy,
   output logic                      finish
);

   os_block_u              cur_block;
   os_kind_e               cur_kind;
   lane_mode_e             cur_mode;
   logic                   active;                       // more symbols of cur_block to send
   logic [SYM_IDX_W-1:0]   cnt;
   logic                   sending;

   os_block_u              sel_block;
   os_kind_e               sel_kind;
   lane_mode_e             sel_mode;
   logic [SYM_IDX_W-1:0]   sel_idx;
   logic [SYM_IDX_W-1:0]   last_idx;
   logic                   emit;
   symbol_t [NUM_LANES-1:0] lane_sym;
   logic    [NUM_LANES-1:0] lane_k;

   assign in.ready = !active;                            // pop right after the last symbol

   // either continue the current set or start on the one waiting
   assign sel_block = active ? cur_block : in.block;
   assign sel_kind  = active ? cur_kind  : in.kind;
   assign sel_mode  = active ? cur_mode  : in.lane_mode;
   assign sel_idx   = active ? cnt       : '0;
   assign emit      = active || in.valid;
   assign last_idx  = (sel_kind inside {OS_TS1, OS_TS2}) ? SYM_IDX_W'(TS_LEN - 1)
                                                         : SYM_IDX_W'(SHORT_LEN - 1);

   always_comb begin
      for (int i = 0; i < NUM_LANES; i++) begin
         lane_sym[i] = sel_block.sym[sel_idx];
         if ((sel_kind inside {OS_TS1, OS_TS2}) && sel_idx == SYM_IDX_W'(LANE_SYM_IDX)) begin
            case (sel_mode)
               LANE_PAD: lane_sym[i] = PAD_SYM;
               LANE_SEQ: lane_sym[i] = symbol_t'(i);
               default:  lane_sym[i] = symbol_t'(NUM_LANES - i);   // reversed, counts down to 1
            endcase
         end
         lane_k[i] = lane_sym[i] inside {COM_SYM, PAD_SYM, SKP_SYM, EIDL_SYM};
      end
   end

   always_ff @(posedge pclk or negedge reset_n) begin
      if (!reset_n) begin
         active  <= 1'b0;
         cnt     <= '0;
         sending <= 1'b0;
         finish  <= 1'b0;
         os_out  <= '0;
         data_k  <= '0;
      end else begin
         sending <= emit;
         finish  <= emit && (sel_idx == last_idx);
         os_out  <= emit ? lane_sym : '0;
         data_k  <= emit ? lane_k : '0;
         if (!active && in.valid) begin
            active <= 1'b1;
            cnt    <= SYM_IDX_W'(1);                     // symbol 0 goes out now
         end else if (active) begin
            if (cnt == last_idx) begin
               active <= 1'b0;
            end else begin
               cnt <= cnt + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge pclk) begin
      if (!active && in.valid) begin
         cur_block <= in.block;
         cur_kind  <= in.kind;
         cur_mode  <= in.lane_mode;
      end
   end

   assign data_valid = {NUM_LANES{sending}};
   assign busy       = sending || in.valid;

   a_finish_valid: assert property (@(posedge pclk) disable iff (!reset_n)
      finish |-> data_valid == {NUM_LANES{1'b1}});

endmodule

`default_nettype wire

// File: design/os_queue.sv
`default_nettype none

module os_queue import os_gen_pkg::*; (
   input  wire      pclk,
   input  wire      reset_n,
   os_block_if.dst  in,
   os_block_if.src  out
);

   os_block_u  block_mem [QUEUE_DEPTH];
   os_kind_e   kind_mem  [QUEUE_DEPTH];
   lane_mode_e mode_mem  [QUEUE_DEPTH];

   logic [QPTR_W-1:0] wr_ptr;
   logic [QPTR_W-1:0] rd_ptr;
   logic [QCNT_W-1:0] count;
   logic              push;
   logic              pop;

   assign in.ready  = (count != QCNT_W'(QUEUE_DEPTH));   // back-pressure when full
   assign out.valid = (count != '0);
   assign push      = in.valid && in.ready;
   assign pop       = out.valid && out.ready;

   always_ff @(posedge pclk or negedge reset_n) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                     // idle or pass-through
         endcase
      end
   end

   always_ff @(posedge pclk) begin
      if (push) begin
         block_mem[wr_ptr] <= in.block;
         kind_mem[wr_ptr]  <= in.kind;
         mode_mem[wr_ptr]  <= in.lane_mode;
      end
   end

   assign out.block     = block_mem[rd_ptr];
   assign out.kind      = kind_mem[rd_ptr];
   assign out.lane_mode = mode_mem[rd_ptr];

   a_no_overflow: assert property (@(posedge pclk) disable iff (!reset_n)
      count <= QCNT_W'(QUEUE_DEPTH));

   // an empty count must agree with the pointers, a pop from empty would split them
   a_no_underflow: assert property (@(posedge pclk) disable iff (!reset_n)
      count == '0 |-> rd_ptr == wr_ptr);

endmodule

`default_nettype wire

// File: test/os_clock_gen.sv
`default_nettype none

module os_clock_gen (
   output logic pclk
);

   localparam int HALF_PERIOD = 2;                       // 4 time units per cycle

   initial begin
      pclk = 1'b0;
      forever #HALF_PERIOD pclk = ~pclk;
   end

endmodule

`default_nettype wire

// File: test/os_generator_tb.sv
`default_nettype none

module os_generator_tb import os_gen_pkg::*; ();

   typedef struct {
      os_kind_e   kind;
      logic [1:0] mode;
      symbol_t    link;
      logic [2:0] rate;
      logic       loopback;
   } request_t;

   localparam int WAIT_LIMIT = 200;                      // cycles allowed per wait loop

   logic                    pclk;
   logic                    reset_n;
   logic                    start;
   logic [1:0]              os_type;
   logic [1:0]              lane_number;
   symbol_t                 link_number;
   logic [2:0]              rate;
   logic                    loopback;
   logic                    ready;
   logic                    busy;
   logic                    finish;
   symbol_t [NUM_LANES-1:0] os_out;
   logic [NUM_LANES-1:0]    data_k;
   logic [NUM_LANES-1:0]    data_valid;

   request_t exp_q[$];                                   // issued but not yet on the lanes
   request_t cur;
   integer   seed           = 58023;
   int       sym_idx        = 0;
   logic     prev_valid     = 1'b0;
   logic     prev_finish    = 1'b0;
   logic     burst_mode     = 1'b0;                      // no gaps allowed while kept full
   logic     ready_low_seen = 1'b0;

   os_clock_gen clk_i (.pclk(pclk));

   os_generator dut_i (.*);

   function automatic logic [8:0] expected_symbol(request_t r, int idx, int lane);
      symbol_t s;
      s = '0;
      if (r.kind == OS_SKP) begin
         s = (idx == 0) ? COM_SYM : SKP_SYM;
      end else if (r.kind == OS_EIOS) begin
         s = (idx == 0) ? COM_SYM : EIDL_SYM;
      end else begin
         case (idx)
            0: s = COM_SYM;
            1: s = (r.link == 8'h00) ? PAD_SYM : r.link;
            2: s = (r.mode == 2'd0) ? PAD_SYM :
                   (r.mode == 2'd1) ? symbol_t'(lane) : symbol_t'(NUM_LANES - lane);
            3: s = 8'h00;
            4: s = (r.rate >= 3'd1 && r.rate <= 3'd4) ? (8'h01 << r.rate) : 8'h20;
            5: s = r.loopback ? 8'h04 : 8'h00;
            default: s = (r.kind == OS_TS1) ? 8'h4A : 8'h45;
         endcase
      end
      return {(s == COM_SYM || s == PAD_SYM || s == SKP_SYM || s == EIDL_SYM), s};
   endfunction

   function automatic int set_length(os_kind_e k);
      return (k == OS_SKP || k == OS_EIOS) ? SHORT_LEN : TS_LEN;
   endfunction

   function automatic request_t make_request(os_kind_e k, logic [1:0] m, symbol_t l,
                                             logic [2:0] rc, logic lb);
      request_t r;
      r.kind     = k;
      r.mode     = m;
      r.link     = l;
      r.rate     = rc;
      r.loopback = lb;
      return r;
   endfunction

   task automatic abort_run(string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1);
   endtask

   task automatic check_symbol(string name, symbol_t expected, symbol_t actual);
      if (actual !== expected)
         abort_run($sformatf("FAILED at %0t: %s expected %h, got %h",
                             $time, name, expected, actual));
   endtask

   task automatic check_k(string name, logic expected, logic actual);
      if (actual !== expected)
         abort_run($sformatf("FAILED at %0t: %s expected %b, got %b",
                             $time, name, expected, actual));
   endtask

   task automatic check_flag(string name, logic expected, logic actual);
      if (actual !== expected)
         abort_run($sformatf("FAILED at %0t: %s expected %b, got %b",
                             $time, name, expected, actual));
   endtask

   task automatic check_idle_outputs();
      check_flag("data_valid", 1'b0, |data_valid);
      check_flag("data_k", 1'b0, |data_k);
      check_flag("finish", 1'b0, finish);
      check_flag("busy", 1'b0, busy);
      check_flag("ready", 1'b1, ready);
      for (int lane = 0; lane < NUM_LANES; lane++) begin
         check_symbol($sformatf("os_out[%0d]", lane), 8'h00, os_out[lane]);
      end
   endtask

   task automatic wait_for_ready();
      int n;
      n = 0;
      while (!ready) begin
         ready_low_seen = 1'b1;
         if (n == WAIT_LIMIT) abort_run("timeout: ready stayed low, no request can be issued");
         n++;
         @(negedge pclk);
      end
   endtask

   task automatic wait_for_idle();
      int n;
      n = 0;
      while (exp_q.size() != 0 || sym_idx != 0 || busy) begin
         if (n == WAIT_LIMIT) abort_run("timeout: the generator never went idle");
         n++;
         @(negedge pclk);
      end
      @(negedge pclk);                                   // one idle cycle between tests
   endtask

   task automatic drive_request(request_t r);
      start       = 1'b1;
      os_type     = r.kind;
      lane_number = r.mode;
      link_number = r.link;
      rate        = r.rate;
      loopback    = r.loopback;
      exp_q.push_back(r);
   endtask

   task automatic issue_request(request_t r);
      wait_for_ready();
      drive_request(r);
      @(negedge pclk);
      start = 1'b0;
   endtask

   // outputs are registered, so values seen at the rising edge belong to the last cycle
   always @(posedge pclk) begin
      logic [8:0] exp_sym;
      if (reset_n) begin
         if (data_valid[0]) begin
            if (sym_idx == 0) begin
               if (exp_q.size() == 0) abort_run("data_valid went high with no request pending");
               cur = exp_q.pop_front();
            end
            for (int lane = 0; lane < NUM_LANES; lane++) begin
               exp_sym = expected_symbol(cur, sym_idx, lane);
               check_symbol($sformatf("os_out[%0d]", lane), exp_sym[7:0], os_out[lane]);
               check_k($sformatf("data_k[%0d]", lane), exp_sym[8], data_k[lane]);
               check_flag($sformatf("data_valid[%0d]", lane), 1'b1, data_valid[lane]);
            end
            check_flag("finish", sym_idx == set_length(cur.kind) - 1, finish);
            check_flag("busy", 1'b1, busy);
            sym_idx = (sym_idx == set_length(cur.kind) - 1) ? 0 : sym_idx + 1;
         end else begin
            if (sym_idx != 0) abort_run("data_valid dropped in the middle of an ordered set");
            if (burst_mode && prev_valid && exp_q.size() != 0)
               abort_run("idle cycle between back-to-back ordered sets");
            if (prev_finish && exp_q.size() == 0) check_flag("busy", 1'b0, busy);
            check_flag("finish", 1'b0, finish);
            check_flag("data_k", 1'b0, |data_k);
            for (int lane = 0; lane < NUM_LANES; lane++) begin
               check_symbol($sformatf("os_out[%0d]", lane), 8'h00, os_out[lane]);
            end
         end
         prev_valid  = data_valid[0];
         prev_finish = finish;
      end
   end

   initial begin
      request_t    r;
      logic [31:0] rnd;
      reset_n     = 1'b0;
      start       = 1'b0;
      os_type     = 2'd0;
      lane_number = 2'd0;
      link_number = '0;
      rate        = 3'd0;
      loopback    = 1'b0;
      repeat (16) begin
         @(negedge pclk);
         check_idle_outputs();
      end
      reset_n = 1'b1;
      @(negedge pclk);
      check_idle_outputs();

      issue_request(make_request(OS_SKP, 2'd0, 8'h00, 3'd0, 1'b0));
      wait_for_idle();
      issue_request(make_request(OS_EIOS, 2'd1, 8'h00, 3'd0, 1'b0));
      wait_for_idle();

      // every rate code with both loopback values and link 0 on odd codes
      for (int rc = 0; rc < 8; rc++) begin
         for (int lb = 0; lb < 2; lb++) begin
            issue_request(make_request(OS_TS1, 2'd1, rc[0] ? 8'h00 : symbol_t'(8'h21 + rc),
                                       rc[2:0], lb[0]));
            wait_for_idle();
         end
      end

      for (int m = 0; m < 4; m++) begin
         issue_request(make_request(OS_TS2, m[1:0], 8'h05, 3'd1, 1'b0));
         wait_for_idle();
      end

      // first symbol appears after the third rising edge
      check_flag("ready", 1'b1, ready);
      drive_request(make_request(OS_TS1, 2'd2, 8'h33, 3'd2, 1'b1));
      for (int e = 1; e <= 3; e++) begin
         @(negedge pclk);
         start = 1'b0;
         check_flag($sformatf("data_valid after edge %0d", e), e == 3, data_valid[0]);
      end
      wait_for_idle();

      burst_mode     = 1'b1;
      ready_low_seen = 1'b0;
      repeat (24) begin
         rnd = $random(seed);
         issue_request(make_request(os_kind_e'(rnd[1:0]), rnd[3:2], rnd[11:4],
                                    rnd[14:12], rnd[15]));
      end
      wait_for_idle();
      burst_mode = 1'b0;
      check_flag("ready low during burst", 1'b1, ready_low_seen);

      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire
